// ==== compile.f ====
common/idPkg.sv
rtl/decode/ctrlDecoder.sv
rtl/decode/immGen.sv
rtl/decode/sysCheck.sv
rtl/decode/idStage.sv
rtl/regReadyTable.sv
rtl/idTop.sv
verif/idTb.sv

// ==== verif/idTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module idTb;
    import idPkg::*;

    typedef struct packed {
        logic [31:0] instr;
        logic        instrErr;
        logic        csrErr;
        logic        illegal;
        logic        ecall;
        logic        ebreak;
        logic        mret;
        logic        regWr;
        logic        memRd;
        logic        memWr;
        logic [3:0]  src;      // {aluASrc, aluBSrc, isCsr}
        logic [2:0]  branch;
        logic [5:0]  alu;      // {isMulDiv, isWord, op}
        logic [31:0] imm;
    } testCase_t;

    logic        clk;
    logic        rst;
    logic        inValid;
    logic [63:0] inPc;
    logic [31:0] inInstr;
    logic        block;
    logic        jmp;
    logic        instrError;
    logic        csrError;
    logic        wbValid;
    logic [4:0]  wbRd;
    logic        stall;
    decodedOp_t  dutOut;

    testCase_t   cases[$];
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          limit  = 0;

    idTop #(
        .XLEN  (64),
        .NREGS (32)
    ) u_dut (
        .clk        (clk),
        .rst        (rst),
        .inValid    (inValid),
        .inPc       (inPc),
        .inInstr    (inInstr),
        .block      (block),
        .jmp        (jmp),
        .instrError (instrError),
        .csrError   (csrError),
        .wbValid    (wbValid),
        .wbRd       (wbRd),
        .stall      (stall),
        .out        (dutOut)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if ((limit != 0) && (cycles >= limit)) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic expectEq(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got 0x%0h expected 0x%0h (instr 0x%08h)", name, got, exp, inInstr);
        end
    endtask

    function automatic logic [63:0] randPc();
        return {$urandom, $urandom} & ~64'h3; // word aligned
    endfunction

    task automatic addCase(input logic [31:0] instr, input logic [1:0] errs,
                           input logic [3:0] flags, input logic [2:0] mem,
                           input logic [3:0] src, input logic [2:0] branch,
                           input logic [5:0] alu, input logic [31:0] imm);
        testCase_t c;
        c = {instr, errs, flags, mem, src, branch, alu, imm};
        cases.push_back(c);
    endtask

    // errs {instrErr, csrErr}, flags {illegal, ecall, ebreak, mret}, mem {regWr, memRd, memWr}
    // src {aluASrc, aluBSrc, isCsr}
    task automatic fillTable();
        addCase(32'hFFC12283, 2'b00, 4'b0000, 3'b110, 4'h4, 3'd0, 6'h00, 32'hFFFFFFFC); // lw
        addCase(32'h00007003, 2'b00, 4'b1000, 3'b000, 4'h0, 3'd0, 6'h00, 32'h0); // load f3=7
        addCase(32'h0071B823, 2'b00, 4'b0000, 3'b001, 4'h4, 3'd0, 6'h00, 32'h00000010); // sd
        addCase(32'hFE120FA3, 2'b00, 4'b0000, 3'b001, 4'h4, 3'd0, 6'h00, 32'hFFFFFFFF); // sb
        addCase(32'h00004023, 2'b00, 4'b1000, 3'b000, 4'h0, 3'd0, 6'h00, 32'h0); // store f3=4
        addCase(32'h7FF58513, 2'b00, 4'b0000, 3'b100, 4'h4, 3'd0, 6'h00, 32'h000007FF); // addi
        addCase(32'h40335313, 2'b00, 4'b0000, 3'b100, 4'h4, 3'd0, 6'h0D, 32'h00000403); // srai
        addCase(32'h40109093, 2'b00, 4'b1000, 3'b000, 4'h0, 3'd0, 6'h00, 32'h0); // slli bad f7
        addCase(32'hFFF4849B, 2'b00, 4'b0000, 3'b100, 4'h4, 3'd0, 6'h10, 32'hFFFFFFFF); // addiw
        addCase(32'h0000201B, 2'b00, 4'b1000, 3'b000, 4'h0, 3'd0, 6'h00, 32'h0);
        addCase(32'h003100B3, 2'b00, 4'b0000, 3'b100, 4'h0, 3'd0, 6'h00, 32'h00000001); // add
        addCase(32'h40628233, 2'b00, 4'b0000, 3'b100, 4'h0, 3'd0, 6'h08, 32'h00000404); // sub
        addCase(32'h029403B3, 2'b00, 4'b0000, 3'b100, 4'h0, 3'd0, 6'h20, 32'h00000027); // mul
        addCase(32'h02C5D53B, 2'b00, 4'b0000, 3'b100, 4'h0, 3'd0, 6'h35, 32'h0000002A); // divuw
        addCase(32'h403150BB, 2'b00, 4'b0000, 3'b100, 4'h0, 3'd0, 6'h1D, 32'h00000401); // sraw
        addCase(32'h203100B3, 2'b00, 4'b1000, 3'b000, 4'h0, 3'd0, 6'h00, 32'h0); // OP f7=0x10
        addCase(32'h023120BB, 2'b00, 4'b1000, 3'b000, 4'h0, 3'd0, 6'h00, 32'h0); // OP-32 M f3=2
        addCase(32'h800002B7, 2'b00, 4'b0000, 3'b100, 4'h4, 3'd0, 6'h0F, 32'h80000000); // lui
        addCase(32'h12345317, 2'b00, 4'b0000, 3'b100, 4'hC, 3'd0, 6'h00, 32'h12345000); // auipc
        addCase(32'hFF9FF0EF, 2'b00, 4'b0000, 3'b100, 4'hA, 3'd1, 6'h00, 32'hFFFFFFF8); // jal -8
        addCase(32'h0010006F, 2'b00, 4'b0000, 3'b100, 4'hA, 3'd1, 6'h00, 32'h00000800); // jal
        addCase(32'h004280E7, 2'b00, 4'b0000, 3'b100, 4'hA, 3'd2, 6'h00, 32'h00000004); // jalr
        addCase(32'h004290E7, 2'b00, 4'b1000, 3'b000, 4'h0, 3'd0, 6'h00, 32'h0); // jalr f3=1
        addCase(32'h00208863, 2'b00, 4'b0000, 3'b000, 4'h0, 3'd4, 6'h02, 32'h00000010); // beq
        addCase(32'hFE419EE3, 2'b00, 4'b0000, 3'b000, 4'h0, 3'd5, 6'h02, 32'hFFFFFFFC); // bne
        addCase(32'h0062C463, 2'b00, 4'b0000, 3'b000, 4'h0, 3'd6, 6'h02, 32'h00000008); // blt
        addCase(32'h0062D463, 2'b00, 4'b0000, 3'b000, 4'h0, 3'd7, 6'h02, 32'h00000008); // bge
        addCase(32'h0062E463, 2'b00, 4'b0000, 3'b000, 4'h0, 3'd6, 6'h03, 32'h00000008); // bltu
        addCase(32'h0062F463, 2'b00, 4'b0000, 3'b000, 4'h0, 3'd7, 6'h03, 32'h00000008); // bgeu
        addCase(32'h0062A463, 2'b00, 4'b1000, 3'b000, 4'h0, 3'd0, 6'h00, 32'h0); // branch f3=2
        addCase(32'h00000073, 2'b00, 4'b0100, 3'b100, 4'h7, 3'd0, 6'h0F, 32'h00000000); // ecall
        addCase(32'h00100073, 2'b00, 4'b0010, 3'b100, 4'h7, 3'd0, 6'h0F, 32'h00000001); // ebreak
        addCase(32'h30200073, 2'b00, 4'b0001, 3'b100, 4'h7, 3'd0, 6'h0F, 32'h00000302); // mret
        addCase(32'h10500073, 2'b00, 4'b1000, 3'b000, 4'h0, 3'd0, 6'h00, 32'h0); // wfi
        addCase(32'h300312F3, 2'b00, 4'b0000, 3'b100, 4'h7, 3'd0, 6'h0F, 32'h00000300); // csrrw
        addCase(32'h300312F3, 2'b01, 4'b1000, 3'b000, 4'h0, 3'd0, 6'h00, 32'h0); // csr error
        addCase(32'h00004073, 2'b00, 4'b1000, 3'b000, 4'h0, 3'd0, 6'h00, 32'h0); // SYSTEM f3=4
        addCase(32'h0000000B, 2'b00, 4'b1000, 3'b000, 4'h0, 3'd0, 6'h00, 32'h0); // custom-0
        addCase(32'h00008082, 2'b00, 4'b1000, 3'b000, 4'h0, 3'd0, 6'h00, 32'h0); // compressed
        addCase(32'h003100B3, 2'b10, 4'b1000, 3'b000, 4'h0, 3'd0, 6'h00, 32'h0); // fetch error
    endtask

    // called and returns just after a falling edge
    task automatic applyCase(input testCase_t c);
        logic [63:0] pc;
        pc         = randPc();
        inValid    = 1'b1;
        inPc       = pc;
        inInstr    = c.instr;
        instrError = c.instrErr;
        csrError   = c.csrErr;
        @(negedge clk);
        expectEq("out.valid", dutOut.valid, 1'b1);
        expectEq("stall", stall, 1'b0);
        expectEq("out.pc", dutOut.pc, pc);
        expectEq("out.rd", dutOut.rd, c.instr[11:7]);
        expectEq("out.rs1", dutOut.rs1, c.instr[19:15]);
        expectEq("out.rs2", dutOut.rs2, c.instr[24:20]);
        expectEq("out.csrAddr", dutOut.csrAddr, c.instr[31:20]);
        expectEq("out.illegal", dutOut.illegal, c.illegal);
        expectEq("out.ecall", dutOut.ecall, c.ecall);
        expectEq("out.ebreak", dutOut.ebreak, c.ebreak);
        expectEq("out.mret", dutOut.mret, c.mret);
        if (!c.illegal) begin
            expectEq("out.ctrl.regWr", dutOut.ctrl.regWr, c.regWr);
            expectEq("out.ctrl.memRd", dutOut.ctrl.memRd, c.memRd);
            expectEq("out.ctrl.memWr", dutOut.ctrl.memWr, c.memWr);
            expectEq("out.ctrl.aluASrc", dutOut.ctrl.aluASrc, c.src[3]);
            expectEq("out.ctrl.aluBSrc", dutOut.ctrl.aluBSrc, c.src[2:1]);
            expectEq("out.ctrl.isCsr", dutOut.ctrl.isCsr, c.src[0]);
            expectEq("out.ctrl.branch", dutOut.ctrl.branch, c.branch);
            expectEq("out.ctrl.alu", dutOut.ctrl.alu, c.alu);
            expectEq("out.imm", dutOut.imm, c.imm);
            if (c.memRd || c.memWr) begin
                expectEq("out.ctrl.memOp", dutOut.ctrl.memOp, c.instr[14:12]); // access width
            end
        end
        inValid    = 1'b0;
        instrError = 1'b0;
        csrError   = 1'b0;
        @(negedge clk);
        wbValid = 1'b1; // release whatever rd the entry reserved
        wbRd    = c.instr[11:7];
        @(negedge clk);
        wbValid = 1'b0;
    endtask

    task automatic runHazard(input logic [4:0] rd, input logic [31:0] useWord,
                             input logic expStall, input int waitCycles);
        logic [63:0] usePc;
        int          i;
        usePc   = randPc();
        inValid = 1'b1;
        inPc    = randPc();
        inInstr = {12'd1, 5'd0, 3'd0, rd, 7'h13}; // addi rd, x0, 1
        @(negedge clk);
        expectEq("out.valid", dutOut.valid, 1'b1);
        inPc    = usePc;
        inInstr = useWord;
        @(negedge clk);
        if (expStall) begin
            for (i = 0; i < waitCycles; i++) begin
                expectEq("stall", stall, 1'b1);
                expectEq("out.valid", dutOut.valid, 1'b0);
                @(negedge clk);
            end
            wbValid = 1'b1;
            wbRd    = rd;
            expectEq("stall", stall, 1'b1);
            @(negedge clk);
            wbValid = 1'b0;
        end
        expectEq("stall", stall, 1'b0);
        expectEq("out.valid", dutOut.valid, 1'b1);
        expectEq("out.pc", dutOut.pc, usePc);
        inValid = 1'b0;
        @(negedge clk);
        wbValid = 1'b1;
        wbRd    = rd;
        @(negedge clk);
        wbValid = 1'b0;
    endtask

    task automatic runSquash(input logic [4:0] rd);
        logic [63:0] newPc;
        newPc   = randPc();
        inValid = 1'b1;
        inPc    = randPc();
        inInstr = {12'd1, 5'd0, 3'd0, rd, 7'h13};
        @(negedge clk);
        inInstr = {12'd0, rd, 3'd0, 5'd0, 7'h13}; // reads rd, will wait
        @(negedge clk);
        expectEq("stall", stall, 1'b1);
        jmp     = 1'b1;
        inPc    = newPc;
        inInstr = 32'h12345037;
        #1;
        expectEq("stall", stall, 1'b0);
        expectEq("out.valid", dutOut.valid, 1'b0);
        @(negedge clk);
        jmp     = 1'b0;
        inValid = 1'b0;
        #1;
        expectEq("out.valid", dutOut.valid, 1'b1);
        expectEq("out.pc", dutOut.pc, newPc);
        @(negedge clk);
        wbValid = 1'b1;
        wbRd    = rd;
        @(negedge clk);
        wbValid = 1'b0;
    endtask

    task automatic runHold();
        logic [63:0] pcA;
        logic [63:0] pcB;
        pcA     = randPc();
        pcB     = randPc();
        inValid = 1'b1;
        inPc    = pcA;
        inInstr = 32'h00700013; // addi x0, x0, 7
        @(negedge clk);
        block   = 1'b1;
        inPc    = pcB;
        inInstr = 32'h12345037; // lui x0 offered while blocked
        repeat (3) begin
            expectEq("out.valid", dutOut.valid, 1'b1);
            expectEq("out.pc", dutOut.pc, pcA);
            expectEq("out.imm", dutOut.imm, 32'h7);
            @(negedge clk);
        end
        block = 1'b0;
        @(negedge clk);
        expectEq("out.valid", dutOut.valid, 1'b1);
        expectEq("out.pc", dutOut.pc, pcB);
        expectEq("out.imm", dutOut.imm, 32'h12345000);
        inValid = 1'b0;
        @(negedge clk);
    endtask

    initial begin
        logic [4:0] rd;
        void'($urandom(94));
        clk        = 1'b0;
        rst        = 1'b1;
        inValid    = 1'b0;
        inPc       = '0;
        inInstr    = 32'h00000013;
        block      = 1'b0;
        jmp        = 1'b0;
        instrError = 1'b0;
        csrError   = 1'b0;
        wbValid    = 1'b0;
        wbRd       = '0;
        fillTable();
        limit = 40 * cases.size() + 200;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        expectEq("out.valid", dutOut.valid, 1'b0);
        expectEq("stall", stall, 1'b0);

        foreach (cases[k]) begin
            applyCase(cases[k]);
        end

        rd = ($urandom % 31) + 1;
        runHazard(rd, {12'd0, rd, 3'd0, 5'd0, 7'h13}, 1'b1, ($urandom % 4) + 1); // rs1
        rd = ($urandom % 31) + 1;
        runHazard(rd, {7'd0, rd, 5'd0, 3'd0, 5'd0, 7'h33}, 1'b1, ($urandom % 4) + 1); // rs2
        rd = ($urandom % 31) + 1;
        runHazard(rd, {7'd0, 5'd0, rd, 3'd3, 5'd0, 7'h23}, 1'b1, ($urandom % 4) + 1); // store base
        rd = ($urandom % 31) + 1;
        runHazard(rd, 32'h00000033, 1'b0, 0); // x0 sources
        rd = ($urandom % 31) + 1;
        runHazard(rd, {7'd0, rd, rd, 3'd0, 5'd0, 7'h37}, 1'b0, 0); // U ignores fields
        rd = ($urandom % 31) + 1;
        runHazard(rd, {7'd0, rd, rd, 3'd0, 5'd0, 7'h6F}, 1'b0, 0); // J ignores fields

        rd = ($urandom % 31) + 1;
        runSquash(rd);
        runHold();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/idTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module idTop #(
    parameter int XLEN  = 64,
    parameter int NREGS = 32
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     inValid,
    input  logic [XLEN-1:0]          inPc,
    input  logic [31:0]              inInstr,
    input  logic                     block,
    input  logic                     jmp,
    input  logic                     instrError,
    input  logic                     csrError,
    input  logic                     wbValid,
    input  logic [$clog2(NREGS)-1:0] wbRd,
    output logic                     stall,
    output idPkg::decodedOp_t        out
);

    logic rs1Ready;
    logic rs2Ready;
    logic issue;

    // only an issued op that will write back reserves its rd
    // trapping ops never reach write-back
    assign issue = out.valid & ~block & out.ctrl.regWr & ~out.illegal;

    idStage #(
        .XLEN (XLEN)
    ) u_idStage (
        .clk        (clk),
        .rst        (rst),
        .inValid    (inValid),
        .inPc       (inPc),
        .inInstr    (inInstr),
        .block      (block),
        .jmp        (jmp),
        .instrError (instrError),
        .csrError   (csrError),
        .rs1Ready   (rs1Ready),
        .rs2Ready   (rs2Ready),
        .stall      (stall),
        .out        (out)
    );

    regReadyTable #(
        .NREGS (NREGS)
    ) u_regReadyTable (
        .clk      (clk),
        .rst      (rst),
        .issue    (issue),
        .issueRd  (out.rd),
        .wbValid  (wbValid),
        .wbRd     (wbRd),
        .rs1      (out.rs1),
        .rs2      (out.rs2),
        .rs1Ready (rs1Ready),
        .rs2Ready (rs2Ready)
    );

endmodule

`default_nettype wire

// ==== rtl/regReadyTable.sv ====
`timescale 1ns/1ps
`default_nettype none

module regReadyTable #(
    parameter int NREGS = 32
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     issue,
    input  logic [$clog2(NREGS)-1:0] issueRd,
    input  logic                     wbValid,
    input  logic [$clog2(NREGS)-1:0] wbRd,
    input  logic [$clog2(NREGS)-1:0] rs1,
    input  logic [$clog2(NREGS)-1:0] rs2,
    output logic                     rs1Ready,
    output logic                     rs2Ready
);

    logic [NREGS-1:0] pending; // one bit per architectural register

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
        end else begin
            if (wbValid) begin
                pending[wbRd] <= 1'b0;
            end
            // later write, so a same-edge set beats the clear
            if (issue && (issueRd != '0)) begin
                pending[issueRd] <= 1'b1;
            end
        end
    end

    // x0 is never written, so always ready
    assign rs1Ready = (rs1 == '0) | ~pending[rs1];
    assign rs2Ready = (rs2 == '0) | ~pending[rs2];

endmodule

`default_nettype wire

// ==== rtl/decode/idStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module idStage #(
    parameter int XLEN = 64
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               inValid,
    input  logic [XLEN-1:0]    inPc,
    input  logic [31:0]        inInstr,
    input  logic               block,
    input  logic               jmp,
    input  logic               instrError,
    input  logic               csrError,
    input  logic               rs1Ready,
    input  logic               rs2Ready,
    output logic               stall,
    output idPkg::decodedOp_t  out
);
    import idPkg::*;

    logic            validQ;
    logic [XLEN-1:0] pcQ;
    instr_u          instrQ;
    logic            hold;
    logic            opsReady;
    ctrl_t           ctrl;
    immFmt_t         fmt;
    logic            decIllegal;
    logic [31:0]     imm;
    logic            illegal;
    logic            ecall;
    logic            ebreak;
    logic            mret;

    assign hold = block | stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            validQ <= 1'b0;
        end else if (!hold) begin
            validQ <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            pcQ    <= inPc;
            instrQ <= inInstr;
        end
    end

    ctrlDecoder u_ctrlDecoder (
        .instr   (instrQ),
        .ctrl    (ctrl),
        .fmt     (fmt),
        .illegal (decIllegal)
    );

    immGen u_immGen (
        .instrHi (instrQ[31:7]),
        .fmt     (fmt),
        .imm     (imm)
    );

    sysCheck u_sysCheck (
        .instr      (instrQ),
        .isCsr      (ctrl.isCsr),
        .decIllegal (decIllegal),
        .instrError (instrError),
        .csrError   (csrError),
        .illegal    (illegal),
        .ecall      (ecall),
        .ebreak     (ebreak),
        .mret       (mret)
    );

    // source needs by format, R-type comes out as S
    always_comb begin
        case (fmt)
            fmtI:       opsReady = rs1Ready;
            fmtS, fmtB: opsReady = rs1Ready & rs2Ready;
            default:    opsReady = 1'b1; // U, J read no register
        endcase
    end

    assign stall = validQ & ~jmp & ~opsReady; // squash never waits

    always_comb begin
        out         = '0;
        out.valid   = validQ & ~stall & ~jmp;
        out.pc      = pcQ;
        out.rd      = instrQ.r.rd;
        out.rs1     = instrQ.r.rs1;
        out.rs2     = instrQ.r.rs2;
        out.imm     = imm;
        out.csrAddr = instrQ.i.imm12;
        out.ctrl    = ctrl;
        out.illegal = illegal;
        out.ecall   = ecall;
        out.ebreak  = ebreak;
        out.mret    = mret;
    end

endmodule

`default_nettype wire

// ==== rtl/decode/sysCheck.sv ====
`timescale 1ns/1ps
`default_nettype none

module sysCheck (
    input  idPkg::instr_u instr,
    input  logic          isCsr,
    input  logic          decIllegal,
    input  logic          instrError,
    input  logic          csrError,
    output logic          illegal,
    output logic          ecall,
    output logic          ebreak,
    output logic          mret
);
    import idPkg::*;

    logic sysWord;
    logic sysBad;

    assign ecall   = (instr == wordEcall);
    assign ebreak  = (instr == wordEbreak);
    assign mret    = (instr == wordMret);
    assign sysWord = ecall | ebreak | mret;

    // funct3 zero is the privileged group, others are CSR accesses
    assign sysBad = isCsr & ((instr.i.funct3 == 3'b000) ? ~sysWord : csrError);

    assign illegal = decIllegal | instrError | sysBad;

endmodule

`default_nettype wire

// ==== rtl/decode/immGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module immGen (
    input  logic [24:0]    instrHi,
    input  idPkg::immFmt_t fmt,
    output logic [31:0]    imm
);
    import idPkg::*;

    logic [31:7] w; // keeps the instruction bit numbering

    assign w = instrHi;

    always_comb begin
        case (fmt)
            fmtI: imm = {{20{w[31]}}, w[31:20]};
            fmtS: imm = {{20{w[31]}}, w[31:25], w[11:7]};
            fmtB: imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            fmtU: imm = {w[31:12], 12'b0};
            fmtJ: imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/decode/ctrlDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrlDecoder (
    input  idPkg::instr_u  instr,
    output idPkg::ctrl_t   ctrl,
    output idPkg::immFmt_t fmt,
    output logic           illegal
);
    import idPkg::*;

    logic [4:0] op5;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       err;

    assign op5 = instr.r.opcode[6:2];
    assign f3  = instr.r.funct3;
    assign f7  = instr.r.funct7;

    always_comb begin
        ctrl        = '0;
        ctrl.memOp  = f3; // load/store width straight from funct3
        ctrl.branch = none;
        fmt         = fmtI;
        err         = 1'b0;
        case (op5)
            opLoad: begin
                ctrl.regWr   = 1'b1;
                ctrl.memRd   = 1'b1;
                ctrl.aluBSrc = bSrcImm;
                ctrl.alu.op  = aluAdd;
                err          = (f3 == 3'b111);
            end
            opStore: begin
                fmt          = fmtS;
                ctrl.memWr   = 1'b1;
                ctrl.aluBSrc = bSrcImm;
                ctrl.alu.op  = aluAdd;
                err          = f3[2]; // sb..sd only
            end
            opImm: begin
                ctrl.regWr   = 1'b1;
                ctrl.aluBSrc = bSrcImm;
                ctrl.alu.op  = {f7[5] & (f3 == 3'b101), f3};
                // f7[0] is shamt[5] on RV64
                err = ((f3 == 3'b001) && (f7[6:1] != 6'b000000)) ||
                      ((f3 == 3'b101) && (f7[6:1] != 6'b000000) && (f7[6:1] != 6'b010000));
            end
            opImm32: begin
                ctrl.regWr      = 1'b1;
                ctrl.aluBSrc    = bSrcImm;
                ctrl.alu.isWord = 1'b1;
                ctrl.alu.op     = {f7[5] & (f3 == 3'b101), f3};
                case (f3)
                    3'b000:  err = 1'b0;                            // addiw
                    3'b001:  err = (f7 != 7'h00);                   // slliw
                    3'b101:  err = (f7 != 7'h00) && (f7 != 7'h20);  // srliw, sraiw
                    default: err = 1'b1;
                endcase
            end
            opReg: begin
                fmt               = fmtS; // marks the two-source case
                ctrl.regWr        = 1'b1;
                ctrl.aluBSrc      = bSrcRs2;
                ctrl.alu.isMulDiv = f7[0];
                ctrl.alu.op       = {f7[5], f3};
                case (f7)
                    7'h00, 7'h01: err = 1'b0;
                    7'h20:        err = !((f3 == 3'b000) || (f3 == 3'b101)); // sub, sra
                    default:      err = 1'b1;
                endcase
            end
            opReg32: begin
                fmt               = fmtS;
                ctrl.regWr        = 1'b1;
                ctrl.aluBSrc      = bSrcRs2;
                ctrl.alu.isWord   = 1'b1;
                ctrl.alu.isMulDiv = f7[0];
                ctrl.alu.op       = {f7[5], f3};
                case (f7)
                    7'h00:   err = !((f3 == 3'b000) || (f3 == 3'b001) || (f3 == 3'b101));
                    7'h20:   err = !((f3 == 3'b000) || (f3 == 3'b101));
                    7'h01:   err = (f3 == 3'b001) || (f3 == 3'b010) || (f3 == 3'b011);
                    default: err = 1'b1;
                endcase
            end
            opLui: begin
                fmt          = fmtU;
                ctrl.regWr   = 1'b1;
                ctrl.aluBSrc = bSrcImm;
                ctrl.alu.op  = aluPassB;
            end
            opAuipc: begin
                fmt          = fmtU;
                ctrl.regWr   = 1'b1;
                ctrl.aluASrc = 1'b1;
                ctrl.aluBSrc = bSrcImm;
                ctrl.alu.op  = aluAdd;
            end
            opJal: begin
                fmt          = fmtJ;
                ctrl.regWr   = 1'b1;
                ctrl.aluASrc = 1'b1;
                ctrl.aluBSrc = bSrcFour; // rd gets pc+4
                ctrl.alu.op  = aluAdd;
                ctrl.branch  = jal;
            end
            opJalr: begin
                ctrl.regWr   = 1'b1;
                ctrl.aluASrc = 1'b1;
                ctrl.aluBSrc = bSrcFour;
                ctrl.alu.op  = aluAdd;
                ctrl.branch  = jalr;
                err          = (f3 != 3'b000);
            end
            opBranch: begin
                fmt          = fmtB;
                ctrl.aluBSrc = bSrcRs2;
                ctrl.alu.op  = aluCmp;
                case (f3)
                    3'b000: ctrl.branch = eq;
                    3'b001: ctrl.branch = ne;
                    3'b100: ctrl.branch = lt;
                    3'b101: ctrl.branch = ge;
                    3'b110: begin
                        ctrl.branch = lt;
                        ctrl.alu.op = aluCmpU;
                    end
                    3'b111: begin
                        ctrl.branch = ge;
                        ctrl.alu.op = aluCmpU;
                    end
                    default: err = 1'b1;
                endcase
            end
            opSystem: begin
                ctrl.regWr   = 1'b1;
                ctrl.isCsr   = 1'b1;
                ctrl.aluBSrc = bSrcCsr;
                ctrl.alu.op  = aluPassB;
                err          = (f3 == 3'b100); // reserved
            end
            default: err = 1'b1; // unknown opcode
        endcase
    end

    // compressed encodings are not supported
    assign illegal = err | (instr.r.opcode[1:0] != 2'b11);

endmodule

`default_nettype wire

// ==== common/idPkg.sv ====
`default_nettype none

package idPkg;

    // immediate formats
    typedef enum logic [2:0] {
        fmtI = 3'b000,
        fmtJ = 3'b001,
        fmtS = 3'b010,
        fmtB = 3'b011,
        fmtU = 3'b101
    } immFmt_t;

    // unsigned compares reuse lt/ge with aluCmpU
    typedef enum logic [2:0] {
        none = 3'd0,
        jal  = 3'd1,
        jalr = 3'd2,
        eq   = 3'd4,
        ne   = 3'd5,
        lt   = 3'd6,
        ge   = 3'd7
    } branch_t;

    // major opcodes, instr[6:2]
    localparam logic [4:0] opLoad   = 5'b00000;
    localparam logic [4:0] opStore  = 5'b01000;
    localparam logic [4:0] opImm    = 5'b00100;
    localparam logic [4:0] opImm32  = 5'b00110;
    localparam logic [4:0] opReg    = 5'b01100;
    localparam logic [4:0] opReg32  = 5'b01110;
    localparam logic [4:0] opLui    = 5'b01101;
    localparam logic [4:0] opAuipc  = 5'b00101;
    localparam logic [4:0] opJal    = 5'b11011;
    localparam logic [4:0] opJalr   = 5'b11001;
    localparam logic [4:0] opBranch = 5'b11000;
    localparam logic [4:0] opSystem = 5'b11100;

    // operand B select
    localparam logic [1:0] bSrcRs2  = 2'd0;
    localparam logic [1:0] bSrcFour = 2'd1; // link address
    localparam logic [1:0] bSrcImm  = 2'd2;
    localparam logic [1:0] bSrcCsr  = 2'd3;

    localparam logic [3:0] aluAdd   = 4'b0000;
    localparam logic [3:0] aluCmp   = 4'b0010;
    localparam logic [3:0] aluCmpU  = 4'b0011;
    localparam logic [3:0] aluPassB = 4'b1111;

    localparam logic [31:0] wordEcall  = 32'h0000_0073;
    localparam logic [31:0] wordEbreak = 32'h0010_0073;
    localparam logic [31:0] wordMret   = 32'h3020_0073;

    typedef struct packed {
        logic       isMulDiv;
        logic       isWord;
        logic [3:0] op;       // {alt, funct3} or compare/pass codes
    } aluCtr_t;

    typedef struct packed {
        logic       regWr;
        logic       memRd;
        logic       memWr;
        logic [2:0] memOp;
        logic       aluASrc;  // pc as operand A
        logic [1:0] aluBSrc;
        aluCtr_t    alu;
        branch_t    branch;
        logic       isCsr;
    } ctrl_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instrR_t;

    typedef struct packed {
        logic [11:0] imm12;   // also the CSR address
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instrI_t;

    typedef union packed {
        instrR_t r;
        instrI_t i;
    } instr_u;

    typedef struct packed {
        logic        valid;
        logic [63:0] pc;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm;
        logic [11:0] csrAddr;
        ctrl_t       ctrl;
        logic        illegal;
        logic        ecall;
        logic        ebreak;
        logic        mret;
    } decodedOp_t;

endpackage

`default_nettype wire
